/* all.f */
+incdir+src
src/adc_seq_pkg.sv
src/word_queue.sv
src/wb_host_port.sv
src/cmd_sequencer.sv
src/spi_frame_engine.sv
src/sample_packer.sv
src/adc_seq_top.sv
sim/adc_model.sv
sim/tb_adc_seq.sv

/* sim/tb_adc_seq.sv */
`include "adc_seq_config.svh"
`default_nettype none

module tb_adc_seq
  import adc_seq_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 20;   // ns
  localparam int RESET_CYCLES = 16;
  localparam int ACK_LIMIT    = 64;   // Cycles allowed for one bus ack
  localparam int OVERHEAD     = 100;  // Bus traffic and polling per step
  localparam int FRAME_CYCLES = `CS_HIGH_CYCLES + `SPI_FRAME_BITS;
  localparam int READ_CYCLES  = (`ADC_CH_COUNT + 1) * FRAME_CYCLES;  // Nine frames
  localparam int RD_DELAY     = 1000;
  localparam int SHORT_DELAY  = 10;   // Ends well before the first frame
  localparam int FULL_DELAY   = 300;  // Per read in the overflow test

  // Test lengths in cycles
  localparam int T1_LEN = RESET_CYCLES + OVERHEAD;
  localparam int T2_LEN = READ_CYCLES + RD_DELAY + OVERHEAD;
  localparam int T3_LEN = 2 * FRAME_CYCLES + OVERHEAD;
  localparam int T4_LEN = 3 * OVERHEAD;
  localparam int T5_LEN = RESET_CYCLES + READ_CYCLES + OVERHEAD;
  localparam int T6_LEN = 2 * RESET_CYCLES + 2 * (READ_CYCLES + FULL_DELAY) + 2 * OVERHEAD;
  localparam longint WATCHDOG_NS =
    2 * (T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN + T6_LEN) * CLK_PERIOD;

  // Status word layout
  localparam logic [31:0] ST_FLAGS     = 32'h0000_000f;
  localparam logic [31:0] ST_IDLE      = 32'h0000_0020;

  localparam err_flags_t FLAG_NONE     = '0;
  localparam err_flags_t FLAG_BAD_CMD  = '{bad_cmd: 1'b1, default: 1'b0};
  localparam err_flags_t FLAG_UNEXP    = '{unexp_trig: 1'b1, default: 1'b0};
  localparam err_flags_t FLAG_SHORT    = '{delay_short: 1'b1, default: 1'b0};
  localparam err_flags_t FLAG_OVERFLOW = '{overflow: 1'b1, default: 1'b0};

  logic    clk = 1'b0;
  logic    resetn;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  logic    trigger;
  logic    waiting_for_trig;
  logic    n_cs;
  logic    mosi;
  logic    miso;

  adc_sample_t  sample_table [`ADC_CH_COUNT];
  logic [31:0]  rng_state = 32'h69b4149a;
  result_word_t exp_q [$];  // Expected words from the reference
  result_word_t got_q [$];  // Words read over the bus
  int           error_count  = 0;
  int           errors_start = 0;  // Count when the current test began
  int           test_count   = 0;
  int           failed_count = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  adc_seq_top u_adc_seq_top (
    .clk, .resetn, .wb_req, .wb_rsp, .trigger, .waiting_for_trig, .n_cs, .mosi, .miso
  );

  adc_model u_adc (.clk, .n_cs, .mosi, .miso);

  //////////////////////////////////////////////////
  // Stimulus helpers

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'((lcg_next() >> 16) % n);  // High bits, the low ones cycle fast
  endfunction

  function automatic cmd_word_t make_cmd(input logic [2:0] op, input logic trig,
                                         input wait_cnt_t arg);
    cmd_word_t c;
    c.op    = cmd_op_e'(op);  // Unknown codes pass through
    c.trig  = trig;
    c.spare = '0;
    c.arg   = arg;
    return c;
  endfunction

  function automatic err_flags_t status_flags(input logic [31:0] st);
    return err_flags_t'(st[3:0]);
  endfunction

  // Reference: word k pairs entries 2k (lo) and 2k+1 (hi) of the order
  function automatic result_word_t pair_word(input ch_order_t ord, input int k);
    result_word_t w;
    w.lo = sample_table[ord[2 * k]];
    w.hi = sample_table[ord[2 * k + 1]];
    return w;
  endfunction

  function automatic result_word_t single_word(input adc_ch_t ch);
    result_word_t w;
    w.hi = '0;
    w.lo = sample_table[ch];
    return w;
  endfunction

  task automatic apply_reset();
    resetn  = 1'b0;
    wb_req  = '0;
    trigger = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    resetn = 1'b1;
    @(negedge clk);
  endtask

  // One classic cycle, starts and ends on a falling edge
  task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int waited;
    waited = 0;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdata};
    @(negedge clk);
    while (!wb_rsp.ack && (waited < ACK_LIMIT)) begin
      @(negedge clk);
      waited++;
    end
    rdata = wb_rsp.dat;
    if (!wb_rsp.ack) begin
      $display("No ack on bus cycle to address %0d", adr);
      error_count++;
    end
    wb_req = '0;
    @(negedge clk);  // stb low for a cycle
  endtask

  task automatic write_cmd(input cmd_word_t c);
    logic [31:0] unused;
    bus_cycle(1'b1, 2'd0, 32'(c), unused);
  endtask

  task automatic read_result(output result_word_t w);
    logic [31:0] rd;
    bus_cycle(1'b0, 2'd0, 32'd0, rd);
    w = result_word_t'(rd);
  endtask

  task automatic read_status(output logic [31:0] st);
    bus_cycle(1'b0, 2'd1, 32'd0, st);
  endtask

  // Polls status until the masked bits match
  task automatic wait_status(input logic [31:0] mask, input logic [31:0] value,
                             input int max_cycles, input string what);
    logic [31:0] st;
    time         t_end;
    t_end = $time + max_cycles * CLK_PERIOD;
    read_status(st);
    while (((st & mask) != value) && ($time < t_end)) read_status(st);
    if ((st & mask) != value) begin
      $display("Timed out waiting for %s", what);
      error_count++;
    end
  endtask

  task automatic pulse_trigger();
    trigger = 1'b1;
    @(negedge clk);
    trigger = 1'b0;
    @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // Checks

  task automatic check_result(input string name, input result_word_t got,
                              input result_word_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flags(input err_flags_t got, input err_flags_t exp);
    if (got !== exp) begin
      $display("Mismatch err_flags: got %h expected %h", got, exp);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  // Compare process, pairs read words with reference words in order
  always @(negedge clk) begin
    if ((got_q.size() > 0) && (exp_q.size() > 0))
      check_result("res_word", got_q.pop_front(), exp_q.pop_front());
  end

  task automatic drain_results();
    int waited;
    waited = 0;
    while ((got_q.size() != 0) && (exp_q.size() != 0) && (waited < 4)) begin
      @(negedge clk);
      waited++;
    end
    if ((got_q.size() != 0) || (exp_q.size() != 0)) begin
      $display("Result count wrong, %0d read and %0d expected words left unmatched",
               got_q.size(), exp_q.size());
      error_count++;
      got_q.delete();
      exp_q.delete();
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    drain_results();
    errs = error_count - errors_start;
    test_count++;
    if (errs == 0) begin
      $display("Test %0d %s: ok", test_count, name);
    end else begin
      failed_count++;
      $display("Test %0d %s: failed with %0d errors", test_count, name, errs);
    end
    errors_start = error_count;
  endtask

  //////////////////////////////////////////////////
  // Tests

  initial begin
    logic [31:0]  st;
    result_word_t word;
    ch_order_t    order;
    adc_ch_t      ch;
    adc_ch_t      tmp;
    int           j;
    int           waited;
    logic         low_seen;
    for (int i = 0; i < `ADC_CH_COUNT; i++) begin
      sample_table[i]       = adc_sample_t'(lcg_next() >> 16);
      u_adc.sample_table[i] = sample_table[i];
    end
    apply_reset();

    // 1: reset state
    check_bit("n_cs", n_cs, 1'b1);
    check_bit("mosi", mosi, 1'b0);
    check_bit("waiting_for_trig", waiting_for_trig, 1'b0);
    read_status(st);
    check_flags(status_flags(st), FLAG_NONE);
    check_bit("res_not_empty", st[4], 1'b0);
    check_bit("seq_idle", st[5], 1'b1);
    end_test("reset state");

    // 2: shuffled order, then a full read
    for (int i = 0; i < `ADC_CH_COUNT; i++) order[i] = adc_ch_t'(i);
    for (int i = `ADC_CH_COUNT - 1; i > 0; i--) begin
      j        = rand_below(i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    write_cmd(make_cmd(CMD_SET_ORD, 1'b0, wait_cnt_t'(order)));
    write_cmd(make_cmd(CMD_ADC_RD, 1'b0, wait_cnt_t'(RD_DELAY)));
    wait_status(ST_IDLE, ST_IDLE, T2_LEN, "idle after full read");
    for (int k = 0; k < `ADC_CH_COUNT / 2; k++) begin
      exp_q.push_back(pair_word(order, k));
      read_result(word);
      got_q.push_back(word);
    end
    read_status(st);
    check_flags(status_flags(st), FLAG_NONE);
    check_bit("res_not_empty", st[4], 1'b0);
    end_test("full read in loaded order");

    // 3: one named channel
    ch = adc_ch_t'(rand_below(`ADC_CH_COUNT));
    write_cmd(make_cmd(CMD_ADC_RD_CH, 1'b0, wait_cnt_t'(ch)));
    wait_status(ST_IDLE, ST_IDLE, T3_LEN, "idle after single read");
    exp_q.push_back(single_word(ch));
    read_result(word);
    got_q.push_back(word);
    read_status(st);
    check_flags(status_flags(st), FLAG_NONE);
    check_bit("res_not_empty", st[4], 1'b0);
    end_test("single channel read");

    // 4: trigger wait, cancelled delay, stray trigger
    write_cmd(make_cmd(CMD_NO_OP, 1'b1, wait_cnt_t'(3)));
    waited = 0;
    while (!waiting_for_trig && (waited < OVERHEAD)) begin
      @(negedge clk);
      waited++;
    end
    check_bit("waiting_for_trig", waiting_for_trig, 1'b1);
    pulse_trigger();
    pulse_trigger();
    check_bit("waiting_for_trig", waiting_for_trig, 1'b1);  // One pulse still owed
    pulse_trigger();
    check_bit("waiting_for_trig", waiting_for_trig, 1'b0);
    wait_status(ST_IDLE, ST_IDLE, OVERHEAD, "idle after three triggers");
    write_cmd(make_cmd(CMD_NO_OP, 1'b0, wait_cnt_t'(100000)));  // Far past the watchdog
    write_cmd(make_cmd(CMD_CANCEL, 1'b0, '0));
    wait_status(ST_IDLE, ST_IDLE, OVERHEAD, "idle after cancel");
    read_status(st);
    check_flags(status_flags(st), FLAG_NONE);
    pulse_trigger();  // Sequencer idle here
    read_status(st);
    check_flags(status_flags(st), FLAG_UNEXP);
    end_test("trigger wait and cancel");

    // 5: unknown opcode halts the sequencer
    apply_reset();
    write_cmd(make_cmd(3'd5, 1'b0, '0));
    write_cmd(make_cmd(CMD_ADC_RD, 1'b0, wait_cnt_t'(FULL_DELAY)));
    low_seen = 1'b0;
    repeat (READ_CYCLES) begin
      @(negedge clk);
      if (n_cs == 1'b0) low_seen = 1'b1;
    end
    check_bit("n_cs low seen", low_seen, 1'b0);
    read_status(st);
    check_flags(status_flags(st), FLAG_BAD_CMD);
    check_bit("res_not_empty", st[4], 1'b0);
    check_bit("seq_idle", st[5], 1'b0);
    exp_q.push_back('0);  // Empty queue reads zero
    read_result(word);
    got_q.push_back(word);
    end_test("bad opcode");

    // 6: delay too short, then result overflow
    apply_reset();
    write_cmd(make_cmd(CMD_ADC_RD, 1'b0, wait_cnt_t'(SHORT_DELAY)));
    wait_status({28'd0, FLAG_SHORT}, {28'd0, FLAG_SHORT}, OVERHEAD, "delay_short");
    read_status(st);
    check_flags(status_flags(st), FLAG_SHORT);  // No other flag alongside
    apply_reset();
    write_cmd(make_cmd(CMD_ADC_RD, 1'b0, wait_cnt_t'(FULL_DELAY)));
    write_cmd(make_cmd(CMD_ADC_RD, 1'b0, wait_cnt_t'(FULL_DELAY)));
    wait_status({28'd0, FLAG_OVERFLOW}, {28'd0, FLAG_OVERFLOW},
                2 * (READ_CYCLES + FULL_DELAY) + OVERHEAD, "overflow");
    read_status(st);
    check_flags(status_flags(st), FLAG_OVERFLOW);
    check_bit("res_not_empty", st[4], 1'b1);
    // First read survives in the queue, order back to natural after reset
    for (int i = 0; i < `ADC_CH_COUNT; i++) order[i] = adc_ch_t'(i);
    for (int k = 0; k < `RESULT_QUEUE_DEPTH; k++) begin
      exp_q.push_back(pair_word(order, k));
      read_result(word);
      got_q.push_back(word);
    end
    read_status(st);
    check_bit("res_not_empty", st[4], 1'b0);
    end_test("short delay and overflow");

    $display("%0d tests run, %0d failed, %0d errors", test_count, failed_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/adc_model.sv */
`include "adc_seq_config.svh"
`default_nettype none

module adc_model
  import adc_seq_pkg::*;
(
  input  logic clk,
  input  logic n_cs,
  input  logic mosi,
  output logic miso
);

  timeunit 1ns;
  timeprecision 1ps;

  adc_sample_t sample_table [`ADC_CH_COUNT];  // Written by the testbench at time zero
  logic [3:0]  bit_idx = '0;                  // Edges seen in the current frame
  logic [15:0] rx_word = '0;                  // Request bits shifted in from mosi
  adc_sample_t tx_word = '0;                  // Answer for the frame on the wire

  // MSB first, held steady across each sampling edge
  assign miso = (n_cs === 1'b0) ? tx_word[4'd15 - bit_idx] : 1'b0;

  //////////////////////////////////////////////////
  // Frame decode

  always @(posedge clk) begin : shift_frame
    logic [15:0] req_word;
    if (n_cs !== 1'b0) begin
      bit_idx <= '0;  // A frame cut short by reset starts over
    end else begin
      req_word = {rx_word[14:0], mosi};
      rx_word  <= req_word;
      bit_idx  <= bit_idx + 1'b1;
      // Last bit in, answer goes out during the next frame
      if (bit_idx == 4'd15) begin
        if (req_word[15:14] == `REQ_PREFIX)
          tx_word <= sample_table[req_word[13:11]];
        else
          tx_word <= '0;  // Not a request frame
      end
    end
  end

endmodule

`default_nettype wire

/* src/adc_seq_top.sv */
`include "adc_seq_config.svh"
`default_nettype none

module adc_seq_top
  import adc_seq_pkg::*;
(
  input  logic    clk,
  input  logic    resetn,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp,
  input  logic    trigger,
  output logic    waiting_for_trig,
  output logic    n_cs,
  output logic    mosi,
  input  logic    miso
);

  // Command path
  logic         cmd_push, cmd_full, cmd_pop, cmd_valid;
  cmd_word_t    cmd_data, cmd_head;
  // Result path
  logic         res_push, res_full, res_pop, res_not_empty;
  result_word_t res_data, res_head;
  // Sequencer links
  err_flags_t   err;
  logic         seq_idle, overflow;
  frame_req_t   frame_req;
  frame_rsp_t   frame_rsp;
  sample_push_t sample_push;

  wb_host_port u_host (
    .clk, .resetn, .wb_req, .wb_rsp,
    .cmd_push, .cmd_data, .cmd_full,
    .res_pop, .res_head, .res_not_empty,
    .err, .seq_idle
  );

  word_queue #(.T(cmd_word_t), .DEPTH(`CMD_QUEUE_DEPTH)) u_cmd_queue (
    .clk, .resetn,
    .push(cmd_push), .push_data(cmd_data), .full(cmd_full),
    .pop(cmd_pop), .head(cmd_head), .not_empty(cmd_valid)
  );

  cmd_sequencer u_seq (
    .clk, .resetn, .cmd_head, .cmd_valid, .cmd_pop,
    .trigger, .waiting_for_trig, .frame_req, .frame_rsp,
    .sample_push, .overflow, .err, .seq_idle
  );

  spi_frame_engine u_spi (
    .clk, .resetn, .frame_req, .frame_rsp, .n_cs, .mosi, .miso
  );

  sample_packer u_pack (
    .clk, .resetn, .sample_push, .res_push, .res_data, .res_full, .overflow
  );

  word_queue #(.T(result_word_t), .DEPTH(`RESULT_QUEUE_DEPTH)) u_res_queue (
    .clk, .resetn,
    .push(res_push), .push_data(res_data), .full(res_full),
    .pop(res_pop), .head(res_head), .not_empty(res_not_empty)
  );

endmodule

`default_nettype wire

/* src/sample_packer.sv */
`default_nettype none

module sample_packer
  import adc_seq_pkg::*;
(
  input  logic         clk,
  input  logic         resetn,
  input  sample_push_t sample_push,
  output logic         res_push,
  output result_word_t res_data,
  input  logic         res_full,
  output logic         overflow
);

  adc_sample_t first_q;     // First sample of a pair
  logic        have_first;
  logic        emit;        // A word is ready this cycle
  logic        pair_in;

  assign pair_in = sample_push.valid && !sample_push.single;
  assign emit    = sample_push.valid && (sample_push.single || have_first);

  always_comb begin
    if (sample_push.single) begin
      res_data.hi = '0;
      res_data.lo = sample_push.sample;
    end else begin
      res_data.hi = sample_push.sample;  // Second sample
      res_data.lo = first_q;
    end
  end

  // Word dropped on a full queue, flagged to the sequencer
  assign res_push = emit && !res_full;
  assign overflow = emit && res_full;

  always_ff @(posedge clk) begin
    if (!resetn)      have_first <= 1'b0;
    else if (pair_in) have_first <= !have_first;  // Single reads leave pairing alone
  end

  always_ff @(posedge clk) begin
    if (pair_in && !have_first) first_q <= sample_push.sample;
  end

endmodule

`default_nettype wire

/* src/spi_frame_engine.sv */
`include "adc_seq_config.svh"
`default_nettype none

module spi_frame_engine
  import adc_seq_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  input  frame_req_t frame_req,
  output frame_rsp_t frame_rsp,
  output logic       n_cs,
  output logic       mosi,
  input  logic       miso
);

  localparam int HI_BITS  = $clog2(`CS_HIGH_CYCLES + 1);
  localparam int BIT_BITS = $clog2(`SPI_FRAME_BITS + 1);
  localparam int PAD_BITS = `SPI_FRAME_BITS - $bits(`REQ_PREFIX) - $bits(adc_ch_t);

  logic [HI_BITS-1:0]         hi_cnt;   // n_cs high cycles left after start
  logic [BIT_BITS-1:0]        bit_cnt;  // Bits left with n_cs low
  logic [`SPI_FRAME_BITS-1:0] mosi_sh;
  adc_sample_t                miso_sh;
  logic                       n_cs_q;
  logic                       done_q;

  //////////////////////////////////////////////////
  // Chip select and bit timing

  // Start cycle counts as the first high cycle, done lands CS_HIGH_CYCLES + 16 later
  always_ff @(posedge clk) begin
    if (!resetn) begin
      hi_cnt  <= '0;
      bit_cnt <= '0;
      n_cs_q  <= 1'b1;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (frame_req.start) begin
        hi_cnt <= HI_BITS'(`CS_HIGH_CYCLES - 1);
      end else if (hi_cnt != '0) begin
        hi_cnt <= hi_cnt - 1'b1;
        if (hi_cnt == HI_BITS'(1)) begin
          n_cs_q  <= 1'b0;                        // Frame goes active
          bit_cnt <= BIT_BITS'(`SPI_FRAME_BITS);
        end
      end
      if (bit_cnt != '0) begin
        bit_cnt <= bit_cnt - 1'b1;
        if (bit_cnt == BIT_BITS'(1)) begin
          n_cs_q <= 1'b1;  // Last bit taken
          done_q <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Data shifting

  always_ff @(posedge clk) begin
    if (frame_req.start)
      mosi_sh <= {`REQ_PREFIX, frame_req.ch, {PAD_BITS{1'b0}}};  // On-the-fly request
    else if (bit_cnt != '0)
      mosi_sh <= mosi_sh << 1;
    if (bit_cnt != '0) miso_sh <= adc_sample_t'({miso_sh, miso});  // MSB arrives first
  end

  assign n_cs      = n_cs_q;
  assign mosi      = !n_cs_q && mosi_sh[`SPI_FRAME_BITS-1];  // Idle low
  assign frame_rsp = '{done: done_q, sample: miso_sh};

endmodule

`default_nettype wire

/* src/cmd_sequencer.sv */
`include "adc_seq_config.svh"
`default_nettype none

module cmd_sequencer
  import adc_seq_pkg::*;
(
  input  logic         clk,
  input  logic         resetn,
  input  cmd_word_t    cmd_head,
  input  logic         cmd_valid,
  output logic         cmd_pop,
  input  logic         trigger,
  output logic         waiting_for_trig,
  output frame_req_t   frame_req,
  input  frame_rsp_t   frame_rsp,
  output sample_push_t sample_push,
  input  logic         overflow,
  output err_flags_t   err,
  output logic         seq_idle
);

  localparam int IDX_BITS   = $clog2(`ADC_CH_COUNT + 1);
  localparam int LAST_FRAME = `ADC_CH_COUNT;  // Nine frames for eight reads

  seq_state_e          state, state_next;
  wait_cnt_t           delay_cnt, trig_cnt;
  logic                use_trig;      // Read command ends on triggers
  ch_order_t           order;
  logic [IDX_BITS-1:0] frame_idx;     // Frame now on the wire
  logic                req_start;
  adc_ch_t             req_ch, next_ch;
  logic                is_read, last_done, cancel_head, cmd_done, take, bad_op, rd_start;
  err_flags_t          err_new;

  //////////////////////////////////////////////////
  // Command flow

  assign is_read     = (state == SEQ_ADC_RD) || (state == SEQ_ADC_RD_CH);
  assign last_done   = frame_rsp.done && ((state == SEQ_ADC_RD) ?
                       (frame_idx == IDX_BITS'(LAST_FRAME)) : (frame_idx == IDX_BITS'(1)));
  assign cancel_head = cmd_valid && (cmd_head.op == CMD_CANCEL);

  always_comb begin
    case (state)
      SEQ_IDLE:      cmd_done = 1'b1;
      SEQ_DELAY:     cmd_done = (delay_cnt == '0) || cancel_head;
      SEQ_TRIG_WAIT: cmd_done = (trig_cnt == '0) || (trigger && trig_cnt == wait_cnt_t'(1))
                                || cancel_head;
      SEQ_ADC_RD_CH: cmd_done = last_done;
      default:       cmd_done = 1'b0;  // ADC_RD moves on to its wait, ERROR holds
    endcase
  end

  assign take    = cmd_done && cmd_valid;
  assign cmd_pop = take;
  assign bad_op  = take && !(cmd_head.op inside {CMD_NO_OP, CMD_SET_ORD, CMD_ADC_RD,
                                                 CMD_ADC_RD_CH, CMD_CANCEL});

  // New errors this cycle
  assign err_new = '{bad_cmd:     bad_op,
                     unexp_trig:  trigger && (state != SEQ_TRIG_WAIT),
                     delay_short: (state == SEQ_ADC_RD) && !use_trig && (delay_cnt == '0)
                                  && !last_done,
                     overflow:    overflow};

  always_comb begin
    state_next = state;
    if (take) begin
      case (cmd_head.op)
        CMD_NO_OP:     state_next = cmd_head.trig ? SEQ_TRIG_WAIT : SEQ_DELAY;
        CMD_ADC_RD:    state_next = SEQ_ADC_RD;
        CMD_ADC_RD_CH: state_next = SEQ_ADC_RD_CH;
        CMD_SET_ORD,
        CMD_CANCEL:    state_next = SEQ_IDLE;
        default:       state_next = SEQ_ERROR;
      endcase
    end else if (cmd_done) begin
      state_next = SEQ_IDLE;  // Queue empty
    end else if ((state == SEQ_ADC_RD) && last_done) begin
      state_next = use_trig ? SEQ_TRIG_WAIT : SEQ_DELAY;  // Wait out the rest
    end
    if (err_new != '0) state_next = SEQ_ERROR;  // Halt until reset
  end

  //////////////////////////////////////////////////
  // Frame scheduling

  assign rd_start = ((take && (cmd_head.op inside {CMD_ADC_RD, CMD_ADC_RD_CH}))
                     || (is_read && frame_rsp.done && !last_done)) && (err_new == '0);

  always_comb begin
    if (take)
      next_ch = (cmd_head.op == CMD_ADC_RD_CH) ? adc_ch_t'(cmd_head.arg) : order[0];
    else if ((state == SEQ_ADC_RD) && (frame_idx < IDX_BITS'(LAST_FRAME - 1)))
      next_ch = order[adc_ch_t'(frame_idx + 1'b1)];
    else
      next_ch = '0;  // Dummy request, last frame only returns data
  end

  // Every frame but the first returns a real sample
  assign sample_push = '{valid:  is_read && frame_rsp.done && (frame_idx != '0),
                         single: state == SEQ_ADC_RD_CH,
                         sample: frame_rsp.sample};

  //////////////////////////////////////////////////
  // Registers

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= SEQ_IDLE;
      delay_cnt <= '0;
      trig_cnt  <= '0;
      use_trig  <= 1'b0;
      frame_idx <= '0;
      req_start <= 1'b0;
      err       <= '0;
      for (int i = 0; i < `ADC_CH_COUNT; i++) order[i] <= adc_ch_t'(i);  // Natural order
    end else begin
      state     <= state_next;
      req_start <= rd_start;
      err       <= err | err_new;  // Sticky
      if (take && (cmd_head.op inside {CMD_NO_OP, CMD_ADC_RD})) begin
        delay_cnt <= cmd_head.trig ? '0 : cmd_head.arg;
        trig_cnt  <= cmd_head.trig ? cmd_head.arg : '0;
        use_trig  <= cmd_head.trig;
      end else begin
        if (delay_cnt != '0) delay_cnt <= delay_cnt - 1'b1;  // Runs during frames too
        if ((state == SEQ_TRIG_WAIT) && trigger && (trig_cnt != '0)) trig_cnt <= trig_cnt - 1'b1;
      end
      if (take && (cmd_head.op == CMD_SET_ORD))
        order <= ch_order_t'(cmd_head.arg[$bits(ch_order_t)-1:0]);
      if (take)                             frame_idx <= '0;
      else if (is_read && frame_rsp.done) frame_idx <= frame_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_start) req_ch <= next_ch;
  end

  assign frame_req        = '{start: req_start, ch: req_ch};
  assign waiting_for_trig = (state == SEQ_TRIG_WAIT);
  assign seq_idle         = (state == SEQ_IDLE) && !cmd_valid;

endmodule

`default_nettype wire

/* src/wb_host_port.sv */
`default_nettype none

module wb_host_port
  import adc_seq_pkg::*;
(
  input  logic         clk,
  input  logic         resetn,
  input  wb_req_t      wb_req,
  output wb_rsp_t      wb_rsp,
  output logic         cmd_push,
  output cmd_word_t    cmd_data,
  input  logic         cmd_full,
  output logic         res_pop,
  input  result_word_t res_head,
  input  logic         res_not_empty,
  input  err_flags_t   err,
  input  logic         seq_idle
);

  localparam logic [1:0] ADR_DATA   = 2'd0;  // Command write, result read
  localparam logic [1:0] ADR_STATUS = 2'd1;

  logic        ack_q;
  logic [31:0] rdat_q;
  logic        req_new;  // Request not yet acked
  logic        wr_cmd;
  logic        rd_data;
  logic [31:0] status;

  assign req_new = wb_req.cyc && wb_req.stb && !ack_q;
  assign wr_cmd  = req_new && wb_req.we && (wb_req.adr == ADR_DATA);
  assign rd_data = req_new && !wb_req.we && (wb_req.adr == ADR_DATA);

  assign cmd_push = wr_cmd && !cmd_full;           // Held off while queue full
  assign cmd_data = cmd_word_t'(wb_req.dat);
  assign res_pop  = rd_data && res_not_empty;

  // Status word
  assign status = {26'd0, seq_idle, res_not_empty, err};

  // Ack one cycle after the request, withheld for a write into a full queue
  always_ff @(posedge clk) begin
    if (!resetn) ack_q <= 1'b0;
    else         ack_q <= req_new && !(wr_cmd && cmd_full);
  end

  // Read data
  always_ff @(posedge clk) begin
    if (req_new && !wb_req.we) begin
      case (wb_req.adr)
        ADR_DATA:   rdat_q <= res_not_empty ? 32'(res_head) : 32'd0;  // Empty reads zero
        ADR_STATUS: rdat_q <= status;
        default:    rdat_q <= 32'd0;
      endcase
    end
  end

  assign wb_rsp = '{ack: ack_q, dat: rdat_q};

endmodule

`default_nettype wire

/* src/word_queue.sv */
`default_nettype none

module word_queue #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic resetn,
  input  logic push,
  input  T     push_data,
  output logic full,
  input  logic pop,
  output T     head,
  output logic not_empty
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  T                    mem [DEPTH];  // Payload only, no reset
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                do_push;
  logic                do_pop;

  assign full      = (count == CNT_BITS'(DEPTH));
  assign not_empty = (count != '0);
  assign do_push   = push && !full;     // Push into a full queue is lost
  assign do_pop    = pop && not_empty;
  assign head      = mem[rd_ptr];       // Valid while not_empty

  // Pointer advance with wrap, depth need not be a power of two
  function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
    ptr_inc = (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
      if (do_push && !do_pop)      count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* src/adc_seq_pkg.sv */
`include "adc_seq_config.svh"
`default_nettype none

package adc_seq_pkg;

  //////////////////////////////////////////////////
  // Command words

  typedef enum logic [2:0] {
    CMD_NO_OP     = `OP_NO_OP,     // Delay or trigger wait
    CMD_SET_ORD   = `OP_SET_ORD,   // Load sample order
    CMD_ADC_RD    = `OP_ADC_RD,    // Read all channels
    CMD_ADC_RD_CH = `OP_ADC_RD_CH, // Read one channel
    CMD_CANCEL    = `OP_CANCEL     // End a wait early
  } cmd_op_e;

  typedef logic [`WAIT_COUNT_BITS-1:0] wait_cnt_t;

  typedef struct packed {
    cmd_op_e    op;
    logic       trig;   // Wait on triggers instead of delay
    logic [2:0] spare;
    wait_cnt_t  arg;    // Count, order fields or channel
  } cmd_word_t;

  //////////////////////////////////////////////////
  // ADC data

  typedef logic [2:0]  adc_ch_t;
  typedef logic [15:0] adc_sample_t;

  // Sample order table, entry 0 in the low bits
  typedef adc_ch_t [`ADC_CH_COUNT-1:0] ch_order_t;

  typedef struct packed {
    adc_sample_t hi;  // Second sample of a pair
    adc_sample_t lo;  // First sample, or the only one
  } result_word_t;

  typedef struct packed {
    logic bad_cmd;
    logic unexp_trig;
    logic delay_short;
    logic overflow;
  } err_flags_t;

  //////////////////////////////////////////////////
  // Block to block handshakes

  typedef struct packed {
    logic    start;
    adc_ch_t ch;
  } frame_req_t;

  typedef struct packed {
    logic        done;
    adc_sample_t sample;
  } frame_rsp_t;

  typedef struct packed {
    logic        valid;
    logic        single;  // From a single-channel read
    adc_sample_t sample;
  } sample_push_t;

  // Wishbone classic, word addressed
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_DELAY,
    SEQ_TRIG_WAIT,
    SEQ_ADC_RD,
    SEQ_ADC_RD_CH,
    SEQ_ERROR
  } seq_state_e;

endpackage

`default_nettype wire

/* src/adc_seq_config.svh */
`ifndef ADC_SEQ_CONFIG_SVH
`define ADC_SEQ_CONFIG_SVH

`default_nettype none

// Channel count and SPI framing
`define ADC_CH_COUNT        8
`define SPI_FRAME_BITS      16     // One on-the-fly frame
`define CS_HIGH_CYCLES      4      // n_cs high time before each frame, at least 2
`define REQ_PREFIX          2'b10  // Top bits of a sample request frame

// Queue depths
`define CMD_QUEUE_DEPTH     4
`define RESULT_QUEUE_DEPTH  4

// Delay and trigger count width, fills the command argument
`define WAIT_COUNT_BITS     25

// Command opcodes
`define OP_NO_OP            3'd0
`define OP_SET_ORD          3'd1
`define OP_ADC_RD           3'd2
`define OP_ADC_RD_CH        3'd3
`define OP_CANCEL           3'd7

`default_nettype wire

`endif
